// ==== files.f ====
bp_pkg.sv
branch_resolve.sv
bht_fifo_ptr.sv
bht_array.sv
flush_fsm.sv
pc_select.sv
branch_predictor_unit.sv
branch_predictor_checker.sv
tb_branch_predictor.sv

// ==== tb_branch_predictor.sv ====
`timescale 1ns/1ps

module tb_branch_predictor;

	// about 145 cycles of stimulus with some margin
	localparam int stim_cycles = 160;
	localparam int timeout_cycles = 2 * stim_cycles;

	logic CLK;
	logic nrst;
	logic en;
	logic [bp_pkg::pc_w-1:0] id_pc;
	logic [bp_pkg::pc_w-1:0] id_branchtarget;
	logic id_is_jump;
	logic id_is_btype;
	logic [bp_pkg::pc_w-1:0] exe_pc;
	logic exe_z;
	logic exe_less;
	logic [5:0] exe_btype;
	logic [1:0] exe_c_btype;
	logic [bp_pkg::pc_w-1:0] if_pc;
	logic if_prediction;
	logic [bp_pkg::pc_w-1:0] if_pbt;
	logic [1:0] exe_correction;
	logic [bp_pkg::pc_w-1:0] exe_pbt;
	logic [bp_pkg::pc_w-1:0] exe_cni;
	logic flush;
	logic id_jump_in_bht;

	int errors;
	int checks;
	int cycle_count;

	branch_predictor_unit branch_predictor_unit_inst (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.id_pc(id_pc),
		.id_branchtarget(id_branchtarget),
		.id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype),
		.exe_pc(exe_pc),
		.exe_z(exe_z),
		.exe_less(exe_less),
		.exe_btype(exe_btype),
		.exe_c_btype(exe_c_btype),
		.if_pc(if_pc),
		.if_prediction(if_prediction),
		.if_pbt(if_pbt),
		.exe_correction(exe_correction),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni),
		.flush(flush),
		.id_jump_in_bht(id_jump_in_bht)
	);

	// 20 ns clock
	always #10 CLK = ~CLK;

	always @(posedge CLK) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("timeout, run stopped after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	////////////////////
	// reference rules
	////////////////////

	// kinds in order beq bne blt bge bltu bgeu c.beqz c.bnez
	function automatic logic branch_taken(input int kind, input logic z, input logic less);
		case (kind)
			0, 6: return z;
			1, 7: return !z;
			2, 4: return less;
			default: return !less;
		endcase
	endfunction

	// 11 redirect to target, 10 redirect to fall-through
	function automatic logic [1:0] expected_correction(input logic pred, input logic taken);
		if (pred == taken) begin
			return 2'b00;
		end
		return taken ? 2'b11 : 2'b10;
	endfunction

	// 2-bit saturating counter
	function automatic logic [1:0] next_count(input logic [1:0] ctr, input logic taken);
		if (taken && ctr != 2'd3) begin
			return ctr + 2'd1;
		end
		if (!taken && ctr != 2'd0) begin
			return ctr - 2'd1;
		end
		return ctr;
	endfunction

	// nonzero so a hit never looks like an empty entry
	function automatic logic [bp_pkg::pc_w-1:0] random_target();
		int unsigned r;
		r = $urandom % 2047 + 1;
		return r[bp_pkg::pc_w-1:0];
	endfunction

	function automatic logic [bp_pkg::tag_w-1:0] random_tag();
		int unsigned r;
		r = $urandom;
		return r[bp_pkg::tag_w-1:0];
	endfunction

	////////////////////
	// stimulus helpers
	////////////////////

	task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %0t %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(negedge CLK);
	endtask

	task automatic clear_inputs();
		id_pc = '0;
		id_branchtarget = '0;
		id_is_jump = 1'b0;
		id_is_btype = 1'b0;
		exe_pc = '0;
		exe_z = 1'b0;
		exe_less = 1'b0;
		exe_btype = '0;
		exe_c_btype = '0;
	endtask

	task automatic reset_dut();
		nrst = 1'b0;
		clear_inputs();
		repeat (8) @(negedge CLK);
		nrst = 1'b1;
	endtask

	task automatic drive_decode(input logic [bp_pkg::pc_w-1:0] pc,
			input logic [bp_pkg::pc_w-1:0] target, input logic jump);
		id_pc = pc;
		id_branchtarget = target;
		id_is_jump = jump;
		id_is_btype = !jump;
	endtask

	// one-hot kind with beq at the msb
	task automatic drive_execute(input logic [bp_pkg::pc_w-1:0] pc, input int kind,
			input logic z, input logic less);
		exe_pc = pc;
		exe_z = z;
		exe_less = less;
		{exe_btype, exe_c_btype} = 8'h80 >> kind;
	endtask

	// fetch walks sequentially up to pc
	task automatic run_to_pc(input logic [bp_pkg::pc_w-1:0] pc);
		int n;
		n = 0;
		while (if_pc !== pc && n < 16) begin
			next_cycle();
			n++;
		end
		if (if_pc !== pc) begin
			errors++;
			$display("fetch pc never reached %0h", pc);
		end
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		logic [bp_pkg::pc_w-1:0] pc_a;
		logic [bp_pkg::pc_w-1:0] tgt_a;
		logic [bp_pkg::pc_w-1:0] hold_pc;
		logic [1:0] ctr;
		logic [1:0] exp_corr;
		logic z;
		logic less;
		logic taken;
		logic [7:0] pattern;
		logic [bp_pkg::tag_w-1:0] tags [0:4];
		logic [bp_pkg::pc_w-1:0] tgts [0:4];
		logic [3:0] set;
		bit dup;
		int assert_failures;
		CLK = 1'b0;
		en = 1'b1;
		errors = 0;
		checks = 0;
		cycle_count = 0;
		void'($urandom(32'h4f4f));
		reset_dut();

		// reset state with empty table and sequential fetch
		check_eq(if_pc, 0, "if_pc after reset");
		check_eq(flush, 0, "flush after reset");
		check_eq(exe_correction, 0, "correction after reset");
		for (int i = 1; i <= 4; i++) begin
			check_eq(if_prediction, 0, "prediction on empty table");
			next_cycle();
			check_eq(if_pc, i, "sequential if_pc");
		end
		en = 1'b0;
		hold_pc = if_pc;
		next_cycle();
		check_eq(if_pc, hold_pc, "if_pc held with en low");
		en = 1'b1;

		// branch install three pcs ahead of fetch
		pc_a = if_pc + 3;
		tgt_a = random_target();
		drive_decode(pc_a, tgt_a, 1'b0);
		next_cycle();
		clear_inputs();
		run_to_pc(pc_a);
		check_eq(if_prediction, 0, "new branch predicts not taken");
		check_eq(if_pbt, tgt_a, "fetch target of new branch");
		// second decode with another target must leave the entry alone
		drive_decode(pc_a, ~tgt_a, 1'b0);
		next_cycle();
		clear_inputs();
		exe_pc = pc_a;
		#1;
		check_eq(exe_pbt, tgt_a, "branch not installed twice");
		next_cycle();

		// jump install flushes one cycle late
		clear_inputs();
		pc_a = if_pc + 4;
		tgt_a = random_target();
		drive_decode(pc_a, tgt_a, 1'b1);
		#1;
		check_eq(id_jump_in_bht, 0, "new jump not in table");
		check_eq(flush, 0, "no flush in jump install cycle");
		next_cycle();
		clear_inputs();
		#1;
		check_eq(flush, 1, "flush after new jump");
		next_cycle();
		check_eq(flush, 0, "jump flush lasts one cycle");
		run_to_pc(pc_a);
		check_eq(if_prediction, 1, "jump predicts taken");
		check_eq(if_pbt, tgt_a, "fetch target of jump");
		next_cycle();
		check_eq(if_pc, tgt_a, "fetch follows predicted jump");
		drive_decode(pc_a, tgt_a, 1'b1);
		#1;
		check_eq(id_jump_in_bht, 1, "known jump found in table");
		check_eq(flush, 0, "no flush for known jump");
		next_cycle();
		clear_inputs();
		#1;
		check_eq(flush, 0, "no late flush for known jump");

		// counter training with each kind in its own set
		reset_dut();
		for (int k = 0; k < 8; k++) begin
			pc_a = {1'b0, random_tag(), k[3:0]};
			tgt_a = random_target();
			drive_decode(pc_a, tgt_a, 1'b0);
			next_cycle();
			clear_inputs();
			// weakly not taken
			ctr = 2'd1;
			for (int n = 0; n < 6; n++) begin
				z = $urandom % 2;
				less = $urandom % 2;
				drive_execute(pc_a, k, z, less);
				#1;
				taken = branch_taken(k, z, less);
				exp_corr = expected_correction(ctr[1], taken);
				check_eq(exe_correction, exp_corr, "correction");
				check_eq(exe_pbt, tgt_a, "execute target");
				// bit 10 of pc_a is clear so the fall-through is pc_a + 1
				check_eq(exe_cni, pc_a + 1, "next instruction");
				ctr = next_count(ctr, taken);
				next_cycle();
			end
			clear_inputs();
		end
		// beq outcomes T T T N N N N T hit both saturation ends
		pc_a = {1'b0, random_tag(), 4'd8};
		tgt_a = random_target();
		drive_decode(pc_a, tgt_a, 1'b0);
		next_cycle();
		clear_inputs();
		ctr = 2'd1;
		pattern = 8'b1110_0001;
		for (int n = 0; n < 8; n++) begin
			taken = pattern[7-n];
			drive_execute(pc_a, 0, taken, 1'b0);
			#1;
			exp_corr = expected_correction(ctr[1], taken);
			check_eq(exe_correction, exp_corr, "training correction");
			ctr = next_count(ctr, taken);
			next_cycle();
		end
		clear_inputs();

		// mispredict in both directions
		reset_dut();
		pc_a = {1'b0, random_tag(), 4'($urandom % 16)};
		tgt_a = random_target();
		drive_decode(pc_a, tgt_a, 1'b0);
		next_cycle();
		clear_inputs();
		// bne with z low is taken against a not-taken prediction
		drive_execute(pc_a, 1, 1'b0, 1'b0);
		#1;
		check_eq(exe_correction, 2'b11, "taken mispredict code");
		check_eq(flush, 1, "flush on mispredict");
		next_cycle();
		clear_inputs();
		#1;
		check_eq(if_pc, tgt_a, "redirect to branch target");
		check_eq(flush, 1, "second flush cycle");
		next_cycle();
		check_eq(flush, 0, "flush pair ends");
		// counter now at 2 so a not-taken outcome mispredicts
		drive_execute(pc_a, 1, 1'b1, 1'b0);
		#1;
		check_eq(exe_correction, 2'b10, "not-taken mispredict code");
		check_eq(flush, 1, "flush on not-taken mispredict");
		next_cycle();
		clear_inputs();
		#1;
		check_eq(if_pc, pc_a + 1, "redirect to next instruction");
		check_eq(flush, 1, "second flush cycle after cni");
		next_cycle();
		check_eq(flush, 0, "flush pair ends after cni");

		// fifo replacement with five distinct tags in one set
		reset_dut();
		set = $urandom % 16;
		for (int i = 0; i < 5; i++) begin
			dup = 1'b1;
			while (dup) begin
				tags[i] = random_tag();
				dup = 1'b0;
				for (int j = 0; j < i; j++) begin
					if (tags[j] == tags[i]) begin
						dup = 1'b1;
					end
				end
			end
			tgts[i] = random_target();
			drive_decode({1'b0, tags[i], set}, tgts[i], 1'b0);
			next_cycle();
		end
		clear_inputs();
		// jump decode shows the hit through id_jump_in_bht
		for (int i = 1; i < 5; i++) begin
			drive_decode({1'b0, tags[i], set}, tgts[i], 1'b1);
			exe_pc = {1'b0, tags[i], set};
			#1;
			check_eq(id_jump_in_bht, 1, "surviving entry hits");
			check_eq(exe_pbt, tgts[i], "surviving entry target");
			next_cycle();
		end
		clear_inputs();
		drive_decode({1'b0, tags[0], set}, tgts[0], 1'b1);
		#1;
		check_eq(id_jump_in_bht, 0, "oldest entry evicted");
		next_cycle();
		clear_inputs();

		// let the last assertions finish
		repeat (2) next_cycle();
		assert_failures =
			branch_predictor_unit_inst.branch_predictor_checker_inst.failures;
		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			assert_failures);
		if (errors == 0 && assert_failures == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== branch_predictor_checker.sv ====
`timescale 1ns/1ps

module branch_predictor_checker (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic [bp_pkg::pc_w-1:0] if_pc,
	input logic [1:0] exe_correction,
	input logic [bp_pkg::pc_w-1:0] exe_pbt,
	input logic [bp_pkg::pc_w-1:0] exe_cni,
	input logic flush
);

	int failures = 0;

	// flush machine leaves reset idle
	flush_after_reset: assert property (@(posedge CLK) !nrst |=> !flush)
		else begin
			failures++;
			$error("flush high right after reset");
		end

	// mispredict flushes in its own cycle
	flush_on_mispredict: assert property (@(posedge CLK) disable iff (!nrst)
		exe_correction[1] |-> flush)
		else begin
			failures++;
			$error("mispredict without flush");
		end

	// and once more in the next cycle
	flush_after_mispredict: assert property (@(posedge CLK) disable iff (!nrst)
		(en && exe_correction[1]) |=> flush)
		else begin
			failures++;
			$error("flush not extended after mispredict");
		end

	// taken mispredict sends fetch to the stored target
	redirect_to_target: assert property (@(posedge CLK) disable iff (!nrst)
		(en && exe_correction == bp_pkg::corr_pbt) |=> (if_pc == $past(exe_pbt)))
		else begin
			failures++;
			$error("fetch pc not redirected to branch target");
		end

	// not-taken mispredict sends fetch past the branch
	redirect_to_cni: assert property (@(posedge CLK) disable iff (!nrst)
		(en && exe_correction == bp_pkg::corr_cni) |=> (if_pc == $past(exe_cni)))
		else begin
			failures++;
			$error("fetch pc not redirected to next instruction");
		end

endmodule

bind branch_predictor_unit branch_predictor_checker branch_predictor_checker_inst (
	.CLK(CLK),
	.nrst(nrst),
	.en(en),
	.if_pc(if_pc),
	.exe_correction(exe_correction),
	.exe_pbt(exe_pbt),
	.exe_cni(exe_cni),
	.flush(flush)
);

// ==== branch_predictor_unit.sv ====
`timescale 1ns/1ps

module branch_predictor_unit (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic [bp_pkg::pc_w-1:0] id_pc,
	input logic [bp_pkg::pc_w-1:0] id_branchtarget,
	input logic id_is_jump,
	input logic id_is_btype,
	input logic [bp_pkg::pc_w-1:0] exe_pc,
	input logic exe_z,
	input logic exe_less,
	input logic [5:0] exe_btype,
	input logic [1:0] exe_c_btype,
	output logic [bp_pkg::pc_w-1:0] if_pc,
	output logic if_prediction,
	output logic [bp_pkg::pc_w-1:0] if_pbt,
	output logic [1:0] exe_correction,
	output logic [bp_pkg::pc_w-1:0] exe_pbt,
	output logic [bp_pkg::pc_w-1:0] exe_cni,
	output logic flush,
	output logic id_jump_in_bht
);

	logic exe_taken;
	logic exe_is_branch;
	logic install_fire;
	logic [bp_pkg::set_w-1:0] id_set;
	logic [bp_pkg::way_w-1:0] install_way;
	logic id_hit;

	// execute outcome from alu flags
	branch_resolve branch_resolve_inst (
		.exe_btype(exe_btype),
		.exe_c_btype(exe_c_btype),
		.exe_z(exe_z),
		.exe_less(exe_less),
		.exe_taken(exe_taken),
		.exe_is_branch(exe_is_branch)
	);

	// fifo replacement pointers
	bht_fifo_ptr bht_fifo_ptr_inst (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.id_set(id_set),
		.install_fire(install_fire),
		.install_way(install_way)
	);

	bht_array bht_array_inst (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.if_pc(if_pc),
		.if_prediction(if_prediction),
		.if_pbt(if_pbt),
		.id_pc(id_pc),
		.id_branchtarget(id_branchtarget),
		.id_is_jump(id_is_jump),
		.id_is_btype(id_is_btype),
		.install_way(install_way),
		.install_fire(install_fire),
		.id_set(id_set),
		.id_hit(id_hit),
		.exe_pc(exe_pc),
		.exe_taken(exe_taken),
		.exe_is_branch(exe_is_branch),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni),
		.exe_correction(exe_correction)
	);

	flush_fsm flush_fsm_inst (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.exe_correction(exe_correction),
		.id_is_jump(id_is_jump),
		.id_hit(id_hit),
		.flush(flush),
		.id_jump_in_bht(id_jump_in_bht)
	);

	// fetch pc register
	pc_select pc_select_inst (
		.CLK(CLK),
		.nrst(nrst),
		.en(en),
		.if_prediction(if_prediction),
		.if_pbt(if_pbt),
		.exe_correction(exe_correction),
		.exe_pbt(exe_pbt),
		.exe_cni(exe_cni),
		.id_jump_in_bht(id_jump_in_bht),
		.id_is_jump(id_is_jump),
		.if_pc(if_pc)
	);

endmodule

// ==== pc_select.sv ====
`timescale 1ns/1ps

module pc_select (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic if_prediction,
	input logic [bp_pkg::pc_w-1:0] if_pbt,
	input logic [1:0] exe_correction,
	input logic [bp_pkg::pc_w-1:0] exe_pbt,
	input logic [bp_pkg::pc_w-1:0] exe_cni,
	input logic id_jump_in_bht,
	input logic id_is_jump,
	output logic [bp_pkg::pc_w-1:0] if_pc
);

	logic [bp_pkg::pc_w-1:0] pc_nxt;
	logic jump_installing;

	// jump missing at decode, its entry is written this cycle
	assign jump_installing = id_is_jump && !id_jump_in_bht;

	////////////////////
	// next pc mux
	////////////////////

	// priority: execute correction, then fetch prediction, then pc+1
	always_comb begin
		pc_nxt = if_pc + 1'b1;
		if (exe_correction[1]) begin
			// 11 -> branch target, 10 -> fall-through
			if (exe_correction == bp_pkg::corr_pbt) begin
				pc_nxt = exe_pbt;
			end else begin
				pc_nxt = exe_cni;
			end
		end else if (!exe_correction[0] && if_prediction && !jump_installing) begin
			pc_nxt = if_pbt;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			if_pc <= '0;
		end else if (en) begin
			if_pc <= pc_nxt;
		end
	end

endmodule

// ==== flush_fsm.sv ====
`timescale 1ns/1ps

module flush_fsm (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic [1:0] exe_correction,
	input logic id_is_jump,
	input logic id_hit,
	output logic flush,
	output logic id_jump_in_bht
);

	logic state;
	logic state_nxt;
	logic mispredict;
	logic jump_miss;

	// correction msb set means execute redirects fetch
	assign mispredict = exe_correction[1];

	// new jump at decode, fetch already went down the wrong path
	assign jump_miss = id_is_jump && !id_hit;

	// known jump, pc_select may trust the predicted target
	assign id_jump_in_bht = id_is_jump && id_hit;

	////////////////////
	// next state
	////////////////////

	// pending holds flush for one more enabled cycle
	assign flush = mispredict || (state == bp_pkg::st_pending);

	always_comb begin
		state_nxt = bp_pkg::st_idle;
		if (mispredict) begin
			state_nxt = bp_pkg::st_pending;
		end else if (jump_miss && !flush) begin
			// no flush this cycle, flush the jump's shadow next cycle
			state_nxt = bp_pkg::st_pending;
		end
	end

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			state <= bp_pkg::st_idle;
		end else if (en) begin
			state <= state_nxt;
		end
	end

endmodule

// ==== bht_array.sv ====
`timescale 1ns/1ps

module bht_array (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic [bp_pkg::pc_w-1:0] if_pc,
	output logic if_prediction,
	output logic [bp_pkg::pc_w-1:0] if_pbt,
	input logic [bp_pkg::pc_w-1:0] id_pc,
	input logic [bp_pkg::pc_w-1:0] id_branchtarget,
	input logic id_is_jump,
	input logic id_is_btype,
	input logic [bp_pkg::way_w-1:0] install_way,
	output logic install_fire,
	output logic [bp_pkg::set_w-1:0] id_set,
	output logic id_hit,
	input logic [bp_pkg::pc_w-1:0] exe_pc,
	input logic exe_taken,
	input logic exe_is_branch,
	output logic [bp_pkg::pc_w-1:0] exe_pbt,
	output logic [bp_pkg::pc_w-1:0] exe_cni,
	output logic [1:0] exe_correction
);

	localparam int row_w = bp_pkg::ways * bp_pkg::entry_w;

	// 16 sets x 4 ways, index is {set, way}
	logic [bp_pkg::entry_w-1:0] table_mem [0:bp_pkg::entries-1];

	// valid and tag compare across one set
	function automatic logic [bp_pkg::ways-1:0] match_row(
		input logic [row_w-1:0] row,
		input logic [bp_pkg::tag_w-1:0] tag
	);
		logic [bp_pkg::entry_w-1:0] e;
		logic [bp_pkg::ways-1:0] hits;
		hits = '0;
		for (int w = 0; w < bp_pkg::ways; w++) begin
			e = row[w*bp_pkg::entry_w +: bp_pkg::entry_w];
			hits[w] = e[bp_pkg::valid_bit] && (e[bp_pkg::tag_hi:bp_pkg::tag_lo] == tag);
		end
		return hits;
	endfunction

	// tags are unique within a set so an or-mux is enough
	// a miss returns all zeros, i.e. not taken and target 0
	function automatic logic [bp_pkg::entry_w-1:0] pick_entry(
		input logic [row_w-1:0] row,
		input logic [bp_pkg::ways-1:0] hits
	);
		logic [bp_pkg::entry_w-1:0] sel;
		sel = '0;
		for (int w = 0; w < bp_pkg::ways; w++) begin
			if (hits[w]) begin
				sel = sel | row[w*bp_pkg::entry_w +: bp_pkg::entry_w];
			end
		end
		return sel;
	endfunction

	// one-hot hit vector to way number
	function automatic logic [bp_pkg::way_w-1:0] hit_way(
		input logic [bp_pkg::ways-1:0] hits
	);
		logic [bp_pkg::way_w-1:0] idx;
		idx = '0;
		for (int w = 0; w < bp_pkg::ways; w++) begin
			if (hits[w]) begin
				idx = w[bp_pkg::way_w-1:0];
			end
		end
		return idx;
	endfunction

	logic [bp_pkg::set_w-1:0] if_set;
	logic [bp_pkg::set_w-1:0] exe_set;
	logic [bp_pkg::tag_w-1:0] if_tag;
	logic [bp_pkg::tag_w-1:0] id_tag;
	logic [bp_pkg::tag_w-1:0] exe_tag;
	logic [row_w-1:0] if_row;
	logic [row_w-1:0] id_row;
	logic [row_w-1:0] exe_row;
	logic [bp_pkg::ways-1:0] if_hits;
	logic [bp_pkg::ways-1:0] id_hits;
	logic [bp_pkg::ways-1:0] exe_hits;
	logic [bp_pkg::entry_w-1:0] if_entry;
	logic [bp_pkg::entry_w-1:0] exe_entry;
	logic [bp_pkg::entry_w-1:0] new_entry;
	logic [bp_pkg::entry_w-1:0] upd_entry;
	logic [bp_pkg::way_w-1:0] exe_way;
	logic [1:0] exe_ctr;
	logic exe_hit;
	logic exe_pred;

	// pc split into set and tag, pc[10] dropped
	assign if_set = if_pc[bp_pkg::set_w-1:0];
	assign id_set = id_pc[bp_pkg::set_w-1:0];
	assign exe_set = exe_pc[bp_pkg::set_w-1:0];
	assign if_tag = if_pc[bp_pkg::tag_w+bp_pkg::set_w-1:bp_pkg::set_w];
	assign id_tag = id_pc[bp_pkg::tag_w+bp_pkg::set_w-1:bp_pkg::set_w];
	assign exe_tag = exe_pc[bp_pkg::tag_w+bp_pkg::set_w-1:bp_pkg::set_w];

	// read all four ways of the three addressed sets
	always_comb begin
		for (int w = 0; w < bp_pkg::ways; w++) begin
			if_row[w*bp_pkg::entry_w +: bp_pkg::entry_w] =
				table_mem[{if_set, w[bp_pkg::way_w-1:0]}];
			id_row[w*bp_pkg::entry_w +: bp_pkg::entry_w] =
				table_mem[{id_set, w[bp_pkg::way_w-1:0]}];
			exe_row[w*bp_pkg::entry_w +: bp_pkg::entry_w] =
				table_mem[{exe_set, w[bp_pkg::way_w-1:0]}];
		end
		if_hits = match_row(if_row, if_tag);
		id_hits = match_row(id_row, id_tag);
		exe_hits = match_row(exe_row, exe_tag);
	end

	////////////////////
	// fetch lookup
	////////////////////

	assign if_entry = pick_entry(if_row, if_hits);
	// counter msb is the prediction
	assign if_prediction = if_entry[bp_pkg::ctr_hi];
	assign if_pbt = if_entry[bp_pkg::tgt_hi:bp_pkg::tgt_lo];

	////////////////////
	// decode install
	////////////////////

	assign id_hit = |id_hits;
	// unseen branch or jump goes into the fifo way of its set
	assign install_fire = (id_is_btype || id_is_jump) && !id_hit;

	always_comb begin
		new_entry = '0;
		new_entry[bp_pkg::valid_bit] = 1'b1;
		new_entry[bp_pkg::tag_hi:bp_pkg::tag_lo] = id_tag;
		new_entry[bp_pkg::tgt_hi:bp_pkg::tgt_lo] = id_branchtarget;
		new_entry[bp_pkg::ctr_hi:bp_pkg::ctr_lo] =
			id_is_jump ? bp_pkg::ctr_init_jump : bp_pkg::ctr_init_branch;
	end

	////////////////////
	// execute lookup and correction
	////////////////////

	assign exe_hit = |exe_hits;
	assign exe_entry = pick_entry(exe_row, exe_hits);
	assign exe_way = hit_way(exe_hits);
	assign exe_ctr = exe_entry[bp_pkg::ctr_hi:bp_pkg::ctr_lo];
	assign exe_pred = exe_entry[bp_pkg::ctr_hi];

	assign exe_pbt = exe_entry[bp_pkg::tgt_hi:bp_pkg::tgt_lo];
	// fall-through address after the branch
	assign exe_cni = {1'b0, exe_tag, exe_set} + 1'b1;

	// taken when predicted not taken -> go to target
	// not taken when predicted taken -> go to cni
	always_comb begin
		exe_correction = bp_pkg::corr_none;
		if (exe_is_branch && (exe_pred != exe_taken)) begin
			exe_correction = exe_taken ? bp_pkg::corr_pbt : bp_pkg::corr_cni;
		end
	end

	// saturating counter step, stays put at 3 and 0
	always_comb begin
		upd_entry = exe_entry;
		if (exe_taken && (exe_ctr != 2'd3)) begin
			upd_entry[bp_pkg::ctr_hi:bp_pkg::ctr_lo] = exe_ctr + 1'b1;
		end else if (!exe_taken && (exe_ctr != 2'd0)) begin
			upd_entry[bp_pkg::ctr_hi:bp_pkg::ctr_lo] = exe_ctr - 1'b1;
		end
	end

	////////////////////
	// table write
	////////////////////

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			// only the valid bits need clearing
			for (int i = 0; i < bp_pkg::entries; i++) begin
				table_mem[i][bp_pkg::valid_bit] <= 1'b0;
			end
		end else if (en) begin
			// one write port, install beats counter update
			if (install_fire) begin
				table_mem[{id_set, install_way}] <= new_entry;
			end else if (exe_is_branch && exe_hit) begin
				table_mem[{exe_set, exe_way}] <= upd_entry;
			end
		end
	end

endmodule

// ==== bht_fifo_ptr.sv ====
`timescale 1ns/1ps

module bht_fifo_ptr (
	input logic CLK,
	input logic nrst,
	input logic en,
	input logic [bp_pkg::set_w-1:0] id_set,
	input logic install_fire,
	output logic [bp_pkg::way_w-1:0] install_way
);

	// one replacement pointer per set
	logic [bp_pkg::way_w-1:0] ptr [0:bp_pkg::sets-1];

	// way the next install in this set will overwrite
	assign install_way = ptr[id_set];

	////////////////////
	// pointer update
	////////////////////

	always_ff @(posedge CLK) begin
		if (!nrst) begin
			for (int s = 0; s < bp_pkg::sets; s++) begin
				ptr[s] <= '0;
			end
		end else if (en) begin
			// oldest way gets replaced, then pointer moves on
			// wraps from 3 back to 0 by width
			if (install_fire) begin
				ptr[id_set] <= ptr[id_set] + 1'b1;
			end
		end
	end

endmodule

// ==== branch_resolve.sv ====
`timescale 1ns/1ps

module branch_resolve (
	input logic [5:0] exe_btype,
	input logic [1:0] exe_c_btype,
	input logic exe_z,
	input logic exe_less,
	output logic exe_taken,
	output logic exe_is_branch
);

	// one-hot branch kind at execute
	// exe_btype: beq bne blt bge bltu bgeu, msb first
	// exe_c_btype: c.beqz c.bnez, msb first
	logic [7:0] kind;
	logic [7:0] cond;

	assign kind = {exe_btype, exe_c_btype};

	// condition each kind needs from the alu flags
	// the alu already did the signed or unsigned compare, so blt and bltu share less
	always_comb begin
		// beq
		cond[7] = exe_z;
		// bne
		cond[6] = !exe_z;
		// blt
		cond[5] = exe_less;
		// bge
		cond[4] = !exe_less;
		// bltu
		cond[3] = exe_less;
		// bgeu
		cond[2] = !exe_less;
		// c.beqz, compare against x0 gives zero flag
		cond[1] = exe_z;
		// c.bnez
		cond[0] = !exe_z;
	end

	// actual outcome, only one kind bit should be set
	assign exe_taken = |(kind & cond);

	// any kind bit marks a real branch in execute
	assign exe_is_branch = |kind;

endmodule

// ==== bp_pkg.sv ====
package bp_pkg;

	////////////////////
	// pc and table geometry
	////////////////////

	// halfword pc width
	localparam int pc_w = 11;

	// pc[3:0] picks the set, pc[9:4] is the tag, pc[10] is not stored
	localparam int set_w = 4;
	localparam int tag_w = 6;

	localparam int ways = 4;
	localparam int way_w = 2;
	localparam int sets = 16;
	localparam int entries = 64;

	////////////////////
	// entry layout
	////////////////////

	// | valid | tag[5:0] | target[10:0] | ctr[1:0] |
	localparam int entry_w = 20;
	localparam int valid_bit = 19;
	localparam int tag_hi = 18;
	localparam int tag_lo = 13;
	localparam int tgt_hi = 12;
	localparam int tgt_lo = 2;
	localparam int ctr_hi = 1;
	localparam int ctr_lo = 0;

	// branches start weakly not taken, jumps strongly taken
	localparam logic [1:0] ctr_init_branch = 2'd1;
	localparam logic [1:0] ctr_init_jump = 2'd3;

	// correction codes seen by fetch and flush logic
	localparam logic [1:0] corr_none = 2'b00;
	localparam logic [1:0] corr_cni = 2'b10;
	localparam logic [1:0] corr_pbt = 2'b11;

	// flush state machine encoding
	localparam logic st_idle = 1'b0;
	localparam logic st_pending = 1'b1;

endpackage
